/* design/icache_snoop_pkg.sv */
package icache_snoop_pkg;

	import icache_types_pkg::*;

	// byte address bits 26 to 2.
	localparam int SNOOP_ADDR_W = 25;

	// one queued data-side write, 61 bits.
	typedef struct packed {
		byte_en_t                be;
		word_t                   data;
		logic [SNOOP_ADDR_W-1:0] addr;
	} snoop_entry_t;

endpackage

/* design/icache_top.sv */
`timescale 1ns/1ps

module icache_top
	import icache_types_pkg::*;
#(
	parameter int LINES            = 64,
	parameter int LINESIZE         = 8,
	parameter int WAYS             = 2,
	parameter int BURST            = 4,
	parameter int SNOOP_DEPTH_LOG2 = 4
) (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        cpu_req,
	input  logic [31:0] cpu_addr,
	output logic        cpu_valid,
	output logic        cpu_done,
	output word_t       cpu_data,
	output logic        mem_req,
	output logic [31:0] mem_addr,
	input  logic        mem_done,
	input  word_t       mem_data,
	input  logic [26:2] snoop_addr,
	input  word_t       snoop_data,
	input  byte_en_t    snoop_be,
	input  logic        snoop_we
);

	l1_icache #(
		.LINES(LINES),
		.LINESIZE(LINESIZE),
		.WAYS(WAYS),
		.BURST(BURST),
		.SNOOP_DEPTH_LOG2(SNOOP_DEPTH_LOG2)
	) u_l1_icache (
		.CLK(CLK),
		.RESET(RESET),
		.cpu_req(cpu_req),
		.cpu_addr(cpu_addr),
		.cpu_valid(cpu_valid),
		.cpu_done(cpu_done),
		.cpu_data(cpu_data),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_done(mem_done),
		.mem_data(mem_data),
		.snoop_addr(snoop_addr),
		.snoop_data(snoop_data),
		.snoop_be(snoop_be),
		.snoop_we(snoop_we)
	);

endmodule

/* design/icache_types_pkg.sv */
package icache_types_pkg;

	localparam int WORD_W         = 32;
	localparam int BYTES_PER_WORD = WORD_W / 8;

	// one instruction or data word.
	typedef logic [WORD_W-1:0] word_t;

	// one enable per byte lane.
	typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

	// byte address bits 31 to 2.
	typedef logic [WORD_W-3:0] word_addr_t;

endpackage

/* design/l1_icache.sv */
`timescale 1ns/1ps

module l1_icache
	import icache_types_pkg::*, icache_snoop_pkg::*;
#(
	parameter int LINES            = 64,
	parameter int LINESIZE         = 8,
	parameter int WAYS             = 2,
	parameter int BURST            = 4,
	parameter int SNOOP_DEPTH_LOG2 = 4
) (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        cpu_req,
	input  logic [31:0] cpu_addr,
	output logic        cpu_valid,
	output logic        cpu_done,
	output word_t       cpu_data,
	output logic        mem_req,
	output logic [31:0] mem_addr,
	input  logic        mem_done,
	input  word_t       mem_data,
	input  logic [26:2] snoop_addr,
	input  word_t       snoop_data,
	input  byte_en_t    snoop_be,
	input  logic        snoop_we
);

	localparam int ADDR_W  = $bits(word_addr_t);
	localparam int OFF_W   = $clog2(LINESIZE);
	localparam int SET_W   = $clog2(LINES);
	localparam int RAM_AW  = SET_W + OFF_W;
	localparam int TAG_W   = ADDR_W - RAM_AW;
	localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1;
	localparam int BURST_W = (BURST > 1) ? $clog2(BURST) : 1;

	typedef enum logic [2:0] {
		st_idle,
		st_snoop_wr,
		st_lookup,
		st_fill,
		st_tag_install
	} state_t;

	state_t             state;
	word_addr_t         read_addr;
	logic               cpu_req_hold;
	logic [OFF_W-1:0]   fill_cnt;
	logic [BURST_W-1:0] burst_left;
	logic [WAY_W-1:0]   cache_mux;
	logic [WAY_W-1:0]   rr_ptr [LINES];

	logic [RAM_AW-1:0]  ram_wr_addr;
	word_t              ram_wr_data;
	byte_en_t           ram_wr_be;
	logic [WAYS-1:0]    ram_we;
	word_t              way_data [WAYS];

	logic [TAG_W-1:0]   tag_rd [WAYS];
	logic [WAYS-1:0]    tag_valid;
	logic [WAYS-1:0]    way_hit;
	logic               hit_any;
	logic [WAY_W-1:0]   hit_way;
	logic [SET_W-1:0]   set_idx;
	logic [TAG_W-1:0]   addr_tag;

	snoop_entry_t       snoop_in;
	snoop_entry_t       snoop_head;
	logic               fifo_empty;
	logic               fifo_pop;

	assign set_idx  = read_addr[RAM_AW-1:OFF_W];
	assign addr_tag = read_addr[ADDR_W-1:RAM_AW];
	assign cpu_data = way_data[cache_mux];

	assign snoop_in = '{be: snoop_be, data: snoop_data, addr: snoop_addr};
	assign fifo_pop = (state == st_idle) && !fifo_empty; // snoops win over fetches.

	snoop_fifo #(
		.DEPTH_LOG2(SNOOP_DEPTH_LOG2)
	) u_snoop_fifo (
		.CLK(CLK),
		.RESET(RESET),
		.wr_en(snoop_we),
		.wr_entry(snoop_in),
		.rd_en(fifo_pop),
		.rd_entry(snoop_head),
		.empty(fifo_empty)
	);

	always_comb begin
		hit_any = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (way_hit[w]) begin
				hit_any = 1'b1;
				hit_way = WAY_W'(w);
			end
		end
	end

	always_ff @(posedge CLK) begin
		ram_we    <= '0;
		cpu_valid <= 1'b0;
		cpu_done  <= 1'b0;
		if (RESET) begin
			state        <= st_idle;
			cpu_req_hold <= 1'b0;
			mem_req      <= 1'b0;
			for (int s = 0; s < LINES; s++)
				rr_ptr[s] <= '0;
		end else begin
			if (cpu_req)
				cpu_req_hold <= 1'b1;
			case (state)
				st_idle: begin
					if (!fifo_empty) begin
						state       <= st_snoop_wr;
						read_addr   <= {{(ADDR_W - SNOOP_ADDR_W){1'b0}}, snoop_head.addr};
						ram_wr_addr <= snoop_head.addr[RAM_AW-1:0];
						ram_wr_data <= snoop_head.data;
						ram_wr_be   <= snoop_head.be;
					end else if (cpu_req || cpu_req_hold) begin
						state        <= st_lookup;
						read_addr    <= cpu_addr[31:2];
						cpu_req_hold <= 1'b0;
						burst_left   <= BURST_W'(BURST - 1);
					end
				end
				st_snoop_wr: begin
					state  <= st_idle;
					ram_we <= way_hit; // only cached copies change.
				end
				st_lookup: begin
					if (hit_any) begin
						cache_mux <= hit_way;
						cpu_valid <= 1'b1;
						if (burst_left == '0) begin
							state    <= st_idle;
							cpu_done <= 1'b1;
						end else begin
							burst_left <= burst_left - 1'b1;
							read_addr  <= read_addr + 1'b1;
						end
					end else begin
						state     <= st_fill;
						mem_req   <= 1'b1;
						mem_addr  <= {read_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}, 2'b00};
						fill_cnt  <= '0;
						cache_mux <= rr_ptr[set_idx]; // victim way.
					end
				end
				st_fill: begin
					if (mem_done) begin
						mem_req           <= 1'b0;
						ram_wr_addr       <= {set_idx, fill_cnt};
						ram_wr_data       <= mem_data;
						ram_wr_be         <= '1;
						ram_we[cache_mux] <= 1'b1;
						fill_cnt          <= fill_cnt + 1'b1;
						if (fill_cnt == OFF_W'(LINESIZE - 1))
							state <= st_tag_install;
					end
				end
				st_tag_install: begin
					state           <= st_lookup; // retry the lookup.
					rr_ptr[set_idx] <= (rr_ptr[set_idx] == WAY_W'(WAYS - 1)) ?
						'0 : rr_ptr[set_idx] + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		tag_ram #(
			.LINES(LINES),
			.TAG_W(TAG_W)
		) u_tag_ram (
			.CLK(CLK),
			.RESET(RESET),
			.rd_set(set_idx),
			.wr_set(set_idx),
			.wr_tag(addr_tag),
			.wr_en((state == st_tag_install) && (cache_mux == WAY_W'(w))),
			.rd_tag(tag_rd[w]),
			.rd_valid(tag_valid[w])
		);

		assign way_hit[w] = tag_valid[w] && (tag_rd[w] == addr_tag);

		line_ram #(
			.DEPTH_LOG2(RAM_AW)
		) u_line_ram (
			.CLK(CLK),
			.wr_addr(ram_wr_addr),
			.wr_data(ram_wr_data),
			.wr_be(ram_wr_be),
			.wr_en(ram_we[w]),
			.rd_addr(read_addr[RAM_AW-1:0]),
			.rd_data(way_data[w])
		);
	end

	a_one_way_hit: assert property (@(posedge CLK) disable iff (RESET)
		(state == st_lookup) |-> $onehot0(way_hit))
		else $error("more than one way hit in one lookup.");

	a_done_in_fill: assert property (@(posedge CLK) disable iff (RESET)
		mem_done |-> (state == st_fill))
		else $error("mem_done outside a line fill.");

endmodule

/* design/line_ram.sv */
`timescale 1ns/1ps

module line_ram
	import icache_types_pkg::*;
#(
	parameter int DEPTH_LOG2 = 9
) (
	input  logic                  CLK,
	input  logic [DEPTH_LOG2-1:0] wr_addr,
	input  word_t                 wr_data,
	input  byte_en_t              wr_be,
	input  logic                  wr_en,
	input  logic [DEPTH_LOG2-1:0] rd_addr,
	output word_t                 rd_data
);

	word_t                 mem [2 ** DEPTH_LOG2];
	logic [DEPTH_LOG2-1:0] rd_addr_q;

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			for (int b = 0; b < BYTES_PER_WORD; b++) begin
				if (wr_be[b])
					mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

	// address register as in a block ram.
	always_ff @(posedge CLK) begin
		rd_addr_q <= rd_addr;
	end

	assign rd_data = mem[rd_addr_q];

endmodule

/* design/snoop_fifo.sv */
`timescale 1ns/1ps

module snoop_fifo
	import icache_snoop_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic         CLK,
	input  logic         RESET,
	input  logic         wr_en,
	input  snoop_entry_t wr_entry,
	input  logic         rd_en,
	output snoop_entry_t rd_entry,
	output logic         empty
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	snoop_entry_t          mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;
	logic                  full;

	assign empty    = (count == '0);
	assign full     = (count == (DEPTH_LOG2 + 1)'(DEPTH));
	assign rd_entry = mem[rd_ptr]; // head shown without delay.

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_ptr] <= wr_entry;
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the snoop writer has no back-pressure.
	a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
		(wr_en && full) |-> rd_en)
		else $error("snoop fifo overflow.");

	a_no_underflow: assert property (@(posedge CLK) disable iff (RESET)
		rd_en |-> !empty)
		else $error("snoop fifo read while empty.");

endmodule

/* design/tag_ram.sv */
`timescale 1ns/1ps

module tag_ram #(
	parameter int LINES = 64,
	parameter int TAG_W = 21
) (
	input  logic                     CLK,
	input  logic                     RESET,
	input  logic [$clog2(LINES)-1:0] rd_set,
	input  logic [$clog2(LINES)-1:0] wr_set,
	input  logic [TAG_W-1:0]         wr_tag,
	input  logic                     wr_en,
	output logic [TAG_W-1:0]         rd_tag,
	output logic                     rd_valid
);

	logic [TAG_W-1:0] tags [LINES];
	logic [LINES-1:0] valid;

	assign rd_tag   = tags[rd_set];
	assign rd_valid = valid[rd_set];

	always_ff @(posedge CLK) begin
		if (wr_en)
			tags[wr_set] <= wr_tag;
	end

	always_ff @(posedge CLK) begin
		if (RESET)
			valid <= '0; // all sets empty.
		else if (wr_en)
			valid[wr_set] <= 1'b1;
	end

endmodule

/* sim/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache
	import icache_types_pkg::*;
();

	localparam int LINES            = 64;
	localparam int LINESIZE         = 8;
	localparam int WAYS             = 2;
	localparam int BURST            = 4;
	localparam int SNOOP_DEPTH_LOG2 = 4;
	localparam int MEM_AW           = 14;
	localparam int N_TESTS          = 6;
	localparam int TEST_CYCLES      = BURST + 3 * LINESIZE + 20;

	logic        CLK;
	logic        RESET;
	logic        cpu_req;
	logic [31:0] cpu_addr;
	logic        cpu_valid;
	logic        cpu_done;
	word_t       cpu_data;
	logic        mem_req;
	logic [31:0] mem_addr;
	logic        mem_done;
	word_t       mem_data;
	logic [26:2] snoop_addr;
	word_t       snoop_data;
	byte_en_t    snoop_be;
	logic        snoop_we;

	integer      seed;
	int          mem_req_count = 0;
	logic        mem_req_q;
	logic [31:0] last_mem_addr;

	icache_top #(
		.LINES(LINES),
		.LINESIZE(LINESIZE),
		.WAYS(WAYS),
		.BURST(BURST),
		.SNOOP_DEPTH_LOG2(SNOOP_DEPTH_LOG2)
	) DUT (
		.CLK(CLK),
		.RESET(RESET),
		.cpu_req(cpu_req),
		.cpu_addr(cpu_addr),
		.cpu_valid(cpu_valid),
		.cpu_done(cpu_done),
		.cpu_data(cpu_data),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_done(mem_done),
		.mem_data(mem_data),
		.snoop_addr(snoop_addr),
		.snoop_data(snoop_data),
		.snoop_be(snoop_be),
		.snoop_we(snoop_we)
	);

	tb_mem_model #(
		.LINESIZE(LINESIZE),
		.MEM_AW(MEM_AW)
	) u_mem_model (
		.CLK(CLK),
		.RESET(RESET),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_done(mem_done),
		.mem_data(mem_data)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// one count per line request.
	always @(posedge CLK) begin
		if (RESET) begin
			mem_req_q <= 1'b0;
		end else begin
			mem_req_q <= mem_req;
			if (mem_req && !mem_req_q) begin
				mem_req_count <= mem_req_count + 1;
				last_mem_addr <= mem_addr;
			end
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic compare_addr(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t ns: %s = %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_with_failure($sformatf("[ERROR] %0t ns: %s = %0d, expected %0d",
				$time, name, got, exp));
	endtask

	function automatic word_t model_word(input logic [31:0] byte_addr);
		return u_mem_model.mem[byte_addr[MEM_AW+1:2]];
	endfunction

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
		input byte_en_t be);
		word_t result;
		result = old_word;
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			if (be[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < 2 ** MEM_AW; i++)
			u_mem_model.mem[i] = $random(seed) ^ word_t'(i * 4);
	endtask

	// the memory image follows the snoop too.
	task automatic push_snoop(input logic [31:0] byte_addr, input word_t data,
		input byte_en_t be);
		@(posedge CLK);
		snoop_we   <= 1'b1;
		snoop_addr <= byte_addr[26:2];
		snoop_data <= data;
		snoop_be   <= be;
		@(posedge CLK);
		snoop_we <= 1'b0;
		u_mem_model.mem[byte_addr[MEM_AW+1:2]] =
			merge_bytes(model_word(byte_addr), data, be);
	endtask

	task automatic fetch_and_check(input logic [31:0] addr, input int exp_reqs,
		input logic [31:0] exp_line, output int words_before_req);
		int reqs_before;
		int seen;
		int waited;
		reqs_before      = mem_req_count;
		seen             = 0;
		waited           = 0;
		words_before_req = -1;
		@(posedge CLK);
		cpu_req  <= 1'b1;
		cpu_addr <= addr;
		@(posedge CLK);
		cpu_req <= 1'b0;
		while (seen < BURST) begin
			@(posedge CLK);
			waited++;
			if (waited > TEST_CYCLES)
				stop_with_failure($sformatf("fetch at %h gave %0d of %0d words in %0d cycles",
					addr, seen, BURST, TEST_CYCLES));
			if (mem_req && words_before_req < 0)
				words_before_req = seen;
			compare_bit("cpu_done", cpu_done, cpu_valid && (seen == BURST - 1));
			if (cpu_valid) begin
				compare_word($sformatf("cpu_data[%0d]", seen), cpu_data,
					model_word(addr + 32'(4 * seen)));
				seen++;
			end
		end
		compare_count("mem_req count", mem_req_count - reqs_before, exp_reqs);
		if (exp_reqs > 0)
			compare_addr("mem_addr", last_mem_addr, exp_line);
	endtask

	task automatic test_after_reset();
		int w;
		@(posedge CLK);
		compare_bit("mem_req", mem_req, 1'b0);
		compare_bit("cpu_valid", cpu_valid, 1'b0);
		compare_bit("cpu_done", cpu_done, 1'b0);
		fetch_and_check(32'h0000_0104, 1, 32'h0000_0100, w);
		compare_count("words before mem_req", w, 0);
	endtask

	task automatic test_miss_fill();
		int w;
		fetch_and_check(32'h0000_0240, 1, 32'h0000_0240, w);
		fetch_and_check(32'h0000_0240, 0, 32'h0, w);
	endtask

	task automatic test_snoop_write();
		word_t d;
		int    w;
		d = $random(seed);
		push_snoop(32'h0000_0248, d, 4'b0101);
		repeat (3) @(posedge CLK);
		fetch_and_check(32'h0000_0240, 0, 32'h0, w);
		d = $random(seed);
		push_snoop(32'h0000_1A48, d, 4'b1001); // same set, other tag.
		repeat (3) @(posedge CLK);
		fetch_and_check(32'h0000_0240, 0, 32'h0, w); // cached line keeps its word.
		fetch_and_check(32'h0000_1A44, 1, 32'h0000_1A40, w);
	endtask

	task automatic test_replacement();
		int w;
		fetch_and_check(32'h0000_0500, 1, 32'h0000_0500, w);
		fetch_and_check(32'h0000_0D00, 1, 32'h0000_0D00, w);
		fetch_and_check(32'h0000_1500, 1, 32'h0000_1500, w);
		fetch_and_check(32'h0000_0D00, 0, 32'h0, w);
		fetch_and_check(32'h0000_0500, 1, 32'h0000_0500, w); // a was the victim.
	endtask

	task automatic test_line_crossing();
		int w;
		fetch_and_check(32'h0000_0258, 1, 32'h0000_0260, w);
		compare_count("words before mem_req", w, 2);
	endtask

	task automatic test_held_request();
		word_t d;
		int    w;
		d = $random(seed);
		push_snoop(32'h0000_010C, d, 4'b1110);
		fetch_and_check(32'h0000_0104, 0, 32'h0, w); // arrives during the snoop write.
	endtask

	initial begin
		repeat (N_TESTS * TEST_CYCLES) @(posedge CLK);
		stop_with_failure($sformatf("watchdog expired after %0d cycles",
			N_TESTS * TEST_CYCLES));
	end

	initial begin
		seed       = 32'hc471_b867;
		RESET      = 1'b1;
		cpu_req    = 1'b0;
		cpu_addr   = '0;
		snoop_we   = 1'b0;
		snoop_addr = '0;
		snoop_data = '0;
		snoop_be   = '0;
		fill_memory();
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;
		test_after_reset();
		test_miss_fill();
		test_snoop_write();
		test_replacement();
		test_line_crossing();
		test_held_request();
		@(posedge CLK);
		$display("all tests passed");
		$finish;
	end

endmodule

/* sim/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
	import icache_types_pkg::*;
#(
	parameter int LINESIZE = 8,
	parameter int MEM_AW   = 14
) (
	input  logic        CLK,
	input  logic        RESET,
	input  logic        mem_req,
	input  logic [31:0] mem_addr,
	output logic        mem_done = 1'b0,
	output word_t       mem_data = '0
);

	word_t             mem [2 ** MEM_AW]; // filled by the testbench.
	logic              busy = 1'b0;
	logic [MEM_AW-1:0] line_base;
	int                next_word;

	always @(posedge CLK) begin
		if (RESET) begin
			busy     <= 1'b0;
			mem_done <= 1'b0;
		end else if (!busy) begin
			if (mem_req) begin
				busy      <= 1'b1;
				line_base <= mem_addr[MEM_AW+1:2];
				mem_data  <= mem[mem_addr[MEM_AW+1:2]];
				mem_done  <= 1'b1;
				next_word <= 1;
			end
		end else if (mem_done) begin
			mem_done <= 1'b0; // one idle cycle between words.
		end else if (next_word == LINESIZE) begin
			busy <= 1'b0;
		end else begin
			mem_data  <= mem[line_base + MEM_AW'(next_word)];
			mem_done  <= 1'b1;
			next_word <= next_word + 1;
		end
	end

endmodule

/* verilog.f */
design/icache_types_pkg.sv
design/icache_snoop_pkg.sv
design/snoop_fifo.sv
design/tag_ram.sv
design/line_ram.sv
design/l1_icache.sv
design/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache.sv
